// ==== htPreamblePkg.sv ====
// HT preamble shared definitions.
// Sample format and preamble length constants.
`default_nettype none

package htPreamblePkg;

  localparam int sampleWidth  = 16;
  localparam int romAddrWidth = 7;
  localparam int symbolLength = 80;
  localparam int stfPeriod    = 16;

  // bit k set means LTF symbol k is sent negated (P-matrix row 0).
  localparam logic [3:0] ltfSign = 4'b0010;

  // one complex sample with i in the upper half of the ROM word.
  typedef struct packed {
    logic signed [sampleWidth-1:0] i;
    logic signed [sampleWidth-1:0] q;
  } iqSample_t;

endpackage

`default_nettype wire

// ==== htStfRom.sv ====
// HT-STF sample table.
// One 16-sample period of the short training field, same Q format as the LTF table.
`timescale 1ns/1ps
`default_nettype none

module htStfRom (
  input  wire [$clog2(htPreamblePkg::stfPeriod)-1:0] addr,
  output htPreamblePkg::iqSample_t                    dout
);

  // period repeats every 16 samples, so the low index bits address it directly.
  always_comb begin
    case (addr)
      4'd0:    dout = 32'h02F202F2;
      4'd1:    dout = 32'hF78D0021;
      4'd2:    dout = 32'hFF2BFAF2;
      4'd3:    dout = 32'h0927FF2B;
      4'd4:    dout = 32'h05E30000;
      4'd5:    dout = 32'h0927FF2B;
      4'd6:    dout = 32'hFF2BFAF2;
      4'd7:    dout = 32'hF78D0021;
      4'd8:    dout = 32'h02F202F2;
      4'd9:    dout = 32'h0021F78D;
      4'd10:   dout = 32'hFAF2FF2B;
      4'd11:   dout = 32'hFF2B0927;
      4'd12:   dout = 32'h000005E3;
      4'd13:   dout = 32'hFF2B0927;
      4'd14:   dout = 32'hFAF2FF2B;
      4'd15:   dout = 32'h0021F78D;
      default: dout = 32'h00000000;
    endcase
  end

endmodule

`default_nettype wire

// ==== htLtfRom.sv ====
// HT-LTF sample table.
// 80 samples of the long training symbol; entries 64..79 repeat entries 0..15.
`timescale 1ns/1ps
`default_nettype none

module htLtfRom (
  input  wire [htPreamblePkg::romAddrWidth-1:0] addr,
  output htPreamblePkg::iqSample_t              dout
);

  always_comb begin
    case (addr)
      7'd0:    dout = 32'h08000400;
      7'd1:    dout = 32'h0F430285;
      7'd2:    dout = 32'hFD1FEC0B;
      7'd3:    dout = 32'h0782FE9C;
      7'd4:    dout = 32'h03220D06;
      7'd5:    dout = 32'hEE7DFF47;
      7'd6:    dout = 32'h00201579;
      7'd7:    dout = 32'h06D4FA1F;
      7'd8:    dout = 32'h0C7C0624;
      7'd9:    dout = 32'hFB180DF6;
      7'd10:   dout = 32'hF1430374;
      7'd11:   dout = 32'h07A81176;
      7'd12:   dout = 32'h02B4F4BC;
      7'd13:   dout = 32'h0C65FD14;
      7'd14:   dout = 32'h05170813;
      7'd15:   dout = 32'hFF5812D1;
      7'd16:   dout = 32'h14000000;
      7'd17:   dout = 32'hFF58ED2F;
      7'd18:   dout = 32'h0517F7ED;
      7'd19:   dout = 32'h0C6502EC;
      7'd20:   dout = 32'h02B40B44;
      7'd21:   dout = 32'h07A8EE8A;
      7'd22:   dout = 32'hF143FC8C;
      7'd23:   dout = 32'hFB18F20A;
      7'd24:   dout = 32'h0C7CF9DC;
      7'd25:   dout = 32'h06D405E1;
      7'd26:   dout = 32'h0020EA87;
      7'd27:   dout = 32'hEE7D00B9;
      7'd28:   dout = 32'h0322F2FA;
      7'd29:   dout = 32'h07820164;
      7'd30:   dout = 32'hFD1F13F5;
      7'd31:   dout = 32'h0F43FD7B;
      7'd32:   dout = 32'h0800FC00;
      7'd33:   dout = 32'h04BA0788;
      7'd34:   dout = 32'hF8AD0A15;
      7'd35:   dout = 32'hEF330443;
      7'd36:   dout = 32'h0A860E4A;
      7'd37:   dout = 32'h08E70134;
      7'd38:   dout = 32'hF848094F;
      7'd39:   dout = 32'hF8C6FF82;
      7'd40:   dout = 32'hFB84E9DC;
      7'd41:   dout = 32'hF0660092;
      7'd42:   dout = 32'hEFB4FB54;
      7'd43:   dout = 32'h099CF7AE;
      7'd44:   dout = 32'hFFA40694;
      7'd45:   dout = 32'hF43D0E74;
      7'd46:   dout = 32'h0BBD0E0D;
      7'd47:   dout = 32'h01930C23;
      7'd48:   dout = 32'hEC000000;
      7'd49:   dout = 32'h0193F3DD;
      7'd50:   dout = 32'h0BBDF1F3;
      7'd51:   dout = 32'hF43DF18C;
      7'd52:   dout = 32'hFFA4F96C;
      7'd53:   dout = 32'h099C0852;
      7'd54:   dout = 32'hEFB404AC;
      7'd55:   dout = 32'hF066FF6E;
      7'd56:   dout = 32'hFB841624;
      7'd57:   dout = 32'hF8C6007E;
      7'd58:   dout = 32'hF848F6B1;
      7'd59:   dout = 32'h08E7FECC;
      7'd60:   dout = 32'h0A86F1B6;
      7'd61:   dout = 32'hEF33FBBD;
      7'd62:   dout = 32'hF8ADF5EB;
      7'd63:   dout = 32'h04BAF878;
      // repeated head of the symbol.
      7'd64:   dout = 32'h08000400;
      7'd65:   dout = 32'h0F430285;
      7'd66:   dout = 32'hFD1FEC0B;
      7'd67:   dout = 32'h0782FE9C;
      7'd68:   dout = 32'h03220D06;
      7'd69:   dout = 32'hEE7DFF47;
      7'd70:   dout = 32'h00201579;
      7'd71:   dout = 32'h06D4FA1F;
      7'd72:   dout = 32'h0C7C0624;
      7'd73:   dout = 32'hFB180DF6;
      7'd74:   dout = 32'hF1430374;
      7'd75:   dout = 32'h07A81176;
      7'd76:   dout = 32'h02B4F4BC;
      7'd77:   dout = 32'h0C65FD14;
      7'd78:   dout = 32'h05170813;
      7'd79:   dout = 32'hFF5812D1;
      default: dout = 32'h00000000;
    endcase
  end

endmodule

`default_nettype wire

// ==== preambleSequencer.sv ====
// HT preamble sequencer.
// Walks one STF symbol and numLtf LTF symbols, applies the P-matrix sign
// and registers one sample per sampleEn.
`timescale 1ns/1ps
`default_nettype none

module preambleSequencer #(
  parameter int numLtf = 2
) (
  input  wire                                   clk,
  input  wire                                   arstN,
  input  wire                                   start,
  input  wire                                   sampleEn,
  input  wire htPreamblePkg::iqSample_t         stfWord,
  input  wire htPreamblePkg::iqSample_t         ltfWord,
  output logic [htPreamblePkg::romAddrWidth-1:0] romAddr,
  output htPreamblePkg::iqSample_t              seqSample,
  output logic                                  seqValid,
  output logic                                  lastSample
);

  localparam int lastIdx = htPreamblePkg::symbolLength - 1;
  localparam int lastLtf = numLtf - 1;

  typedef enum logic [1:0] {
    PhIdle,
    PhStf,
    PhLtf
  } phase_t;

  phase_t                                 phase;
  logic [htPreamblePkg::romAddrWidth-1:0] idx;
  logic [1:0]                             ltfCnt;
  logic                                   accept;
  logic                                   idxWrap;
  logic                                   lastOfBurst;
  logic                                   negate;
  htPreamblePkg::iqSample_t               picked;
  htPreamblePkg::iqSample_t               signedWord;

  // ********************************************************************
  // sample path
  // ********************************************************************

  assign romAddr     = idx;
  assign accept      = (phase != PhIdle) && sampleEn;
  assign idxWrap     = idx == lastIdx[htPreamblePkg::romAddrWidth-1:0];
  assign lastOfBurst = (phase == PhLtf) && idxWrap && (ltfCnt == lastLtf[1:0]);
  assign negate      = (phase == PhLtf) && htPreamblePkg::ltfSign[ltfCnt];
  assign picked      = (phase == PhLtf) ? ltfWord : stfWord;

  // minus rows of P flip both components.
  always_comb begin
    signedWord.i = negate ? -picked.i : picked.i;
    signedWord.q = negate ? -picked.q : picked.q;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      seqSample <= signedWord;
    end
  end

  // ********************************************************************
  // phase and index control
  // ********************************************************************

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase      <= PhIdle;
      idx        <= '0;
      ltfCnt     <= '0;
      seqValid   <= 1'b0;
      lastSample <= 1'b0;
    end else begin
      seqValid   <= accept;
      lastSample <= accept && lastOfBurst;
      if (phase == PhIdle) begin
        // start is only honoured between bursts.
        if (start) begin
          phase  <= PhStf;
          idx    <= '0;
          ltfCnt <= '0;
        end
      end else if (sampleEn) begin
        if (!idxWrap) begin
          idx <= idx + 1'b1;
        end else begin
          idx <= '0;
          if (phase == PhStf) begin
            phase <= PhLtf;
          end else if (ltfCnt == lastLtf[1:0]) begin
            phase <= PhIdle;
          end else begin
            ltfCnt <= ltfCnt + 1'b1;
          end
        end
      end
    end
  end

  // ********************************************************************
  // checks
  // ********************************************************************

  ltfCntRange: assert property (@(posedge clk) disable iff (!arstN)
    (phase != PhIdle) |-> (ltfCnt < numLtf));

  idxRange: assert property (@(posedge clk) disable iff (!arstN)
    idx < htPreamblePkg::symbolLength);

  // a valid may rise in idle only for the final sample of a burst.
  validFromActive: assert property (@(posedge clk) disable iff (!arstN)
    ($rose(seqValid) && (phase == PhIdle)) |-> lastSample);

endmodule

`default_nettype wire

// ==== sampleGain.sv ====
// Output gain stage.
// Shifts I and Q left by gainShift, saturates to 16 bits and registers them.
`timescale 1ns/1ps
`default_nettype none

module sampleGain (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire [1:0]                     gainShift,
  input  wire htPreamblePkg::iqSample_t inSample,
  input  wire                           inValid,
  input  wire                           inLast,
  output htPreamblePkg::iqSample_t      sample,
  output logic                          sampleValid,
  output logic                          burstDone
);

  // three guard bits cover the largest shift.
  localparam int wideWidth = htPreamblePkg::sampleWidth + 3;
  localparam logic signed [wideWidth-1:0] posLimit = (2 ** (htPreamblePkg::sampleWidth - 1)) - 1;
  localparam logic signed [wideWidth-1:0] negLimit = -(2 ** (htPreamblePkg::sampleWidth - 1));

  function automatic logic signed [htPreamblePkg::sampleWidth-1:0] shiftSat(
    input logic signed [htPreamblePkg::sampleWidth-1:0] x,
    input logic [1:0]                                   sh
  );
    logic signed [wideWidth-1:0] wide;
    wide = x;
    wide = wide <<< sh;
    if (wide > posLimit) begin
      return posLimit[htPreamblePkg::sampleWidth-1:0];
    end else if (wide < negLimit) begin
      return negLimit[htPreamblePkg::sampleWidth-1:0];
    end
    return wide[htPreamblePkg::sampleWidth-1:0];
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sample      <= '0;
      sampleValid <= 1'b0;
      burstDone   <= 1'b0;
    end else begin
      sampleValid <= inValid;
      burstDone   <= inLast;
      if (inValid) begin
        sample.i <= shiftSat(inSample.i, gainShift);
        sample.q <= shiftSat(inSample.q, gainShift);
      end
    end
  end

  // the sequencer must flag last only on a valid sample.
  doneWithValid: assert property (@(posedge clk) disable iff (!arstN)
    burstDone |-> sampleValid);

endmodule

`default_nettype wire

// ==== htPreambleTop.sv ====
// HT preamble generator top level.
// Sample tables, sequencer and output gain stage.
`timescale 1ns/1ps
`default_nettype none

module htPreambleTop #(
  parameter int numLtf = 2
) (
  input  wire                      clk,
  input  wire                      arstN,
  input  wire                      start,
  input  wire                      sampleEn,
  input  wire [1:0]                gainShift,
  output htPreamblePkg::iqSample_t sample,
  output logic                     sampleValid,
  output logic                     burstDone
);

  logic [htPreamblePkg::romAddrWidth-1:0] romAddr;
  htPreamblePkg::iqSample_t               stfWord;
  htPreamblePkg::iqSample_t               ltfWord;
  htPreamblePkg::iqSample_t               seqSample;
  logic                                   seqValid;
  logic                                   lastSample;

  // STF table sees the index modulo the period.
  htStfRom uStfRom (
    .addr (romAddr[$clog2(htPreamblePkg::stfPeriod)-1:0]),
    .dout (stfWord)
  );

  htLtfRom uLtfRom (
    .addr (romAddr),
    .dout (ltfWord)
  );

  preambleSequencer #(
    .numLtf (numLtf)
  ) uSequencer (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .sampleEn   (sampleEn),
    .stfWord    (stfWord),
    .ltfWord    (ltfWord),
    .romAddr    (romAddr),
    .seqSample  (seqSample),
    .seqValid   (seqValid),
    .lastSample (lastSample)
  );

  sampleGain uGain (
    .clk         (clk),
    .arstN       (arstN),
    .gainShift   (gainShift),
    .inSample    (seqSample),
    .inValid     (seqValid),
    .inLast      (lastSample),
    .sample      (sample),
    .sampleValid (sampleValid),
    .burstDone   (burstDone)
  );

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
// Testbench clock and reset source.
// 8 ns clock, reset low for the first cycles or while rstReq is high.
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter int halfPeriodNs = 4,
  parameter int resetCycles  = 5
) (
  input  wire  rstReq,
  output logic clk,
  output wire  arstN
);

  logic porDone;

  initial begin
    clk = 1'b0;
    forever #halfPeriodNs clk = ~clk;
  end

  initial begin
    porDone = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    porDone = 1'b1;
  end

  assign arstN = porDone && !rstReq;

endmodule

`default_nettype wire

// ==== htPreambleTb.sv ====
// HT preamble generator testbench.
// Random sampleEn pacing, a reference model of the preamble and a per-test report.
`timescale 1ns/1ps
`default_nettype none

module htPreambleTb;

  localparam int burstLen    = 240;
  localparam int doneTimeout = 2000;
  // a set bit marks a minus sign of P-matrix row 0 in LTF order.
  localparam logic [3:0] pRowMinus = 4'b0010;

  localparam logic [31:0] stfRef [16] = '{
    32'h02F202F2, 32'hF78D0021, 32'hFF2BFAF2, 32'h0927FF2B, 32'h05E30000, 32'h0927FF2B,
    32'hFF2BFAF2, 32'hF78D0021, 32'h02F202F2, 32'h0021F78D, 32'hFAF2FF2B, 32'hFF2B0927,
    32'h000005E3, 32'hFF2B0927, 32'hFAF2FF2B, 32'h0021F78D};

  // refSample rebuilds the cyclic tail from this 64-sample body.
  localparam logic [31:0] ltfRef [64] = '{
    32'h08000400, 32'h0F430285, 32'hFD1FEC0B, 32'h0782FE9C, 32'h03220D06, 32'hEE7DFF47,
    32'h00201579, 32'h06D4FA1F, 32'h0C7C0624, 32'hFB180DF6, 32'hF1430374, 32'h07A81176,
    32'h02B4F4BC, 32'h0C65FD14, 32'h05170813, 32'hFF5812D1, 32'h14000000, 32'hFF58ED2F,
    32'h0517F7ED, 32'h0C6502EC, 32'h02B40B44, 32'h07A8EE8A, 32'hF143FC8C, 32'hFB18F20A,
    32'h0C7CF9DC, 32'h06D405E1, 32'h0020EA87, 32'hEE7D00B9, 32'h0322F2FA, 32'h07820164,
    32'hFD1F13F5, 32'h0F43FD7B, 32'h0800FC00, 32'h04BA0788, 32'hF8AD0A15, 32'hEF330443,
    32'h0A860E4A, 32'h08E70134, 32'hF848094F, 32'hF8C6FF82, 32'hFB84E9DC, 32'hF0660092,
    32'hEFB4FB54, 32'h099CF7AE, 32'hFFA40694, 32'hF43D0E74, 32'h0BBD0E0D, 32'h01930C23,
    32'hEC000000, 32'h0193F3DD, 32'h0BBDF1F3, 32'hF43DF18C, 32'hFFA4F96C, 32'h099C0852,
    32'hEFB404AC, 32'hF066FF6E, 32'hFB841624, 32'hF8C6007E, 32'hF848F6B1, 32'h08E7FECC,
    32'h0A86F1B6, 32'hEF33FBBD, 32'hF8ADF5EB, 32'h04BAF878};

  wire                      clk;
  wire                      arstN;
  logic                     rstReq;
  logic                     start;
  logic                     sampleEn;
  logic [1:0]               gainShift;
  htPreamblePkg::iqSample_t sample;
  logic                     sampleValid;
  logic                     burstDone;
  integer                   seed = 32'h80a88734;
  logic                     enRun;
  logic                     holdLow;
  int                       cyc;
  int                       checks;
  int                       errors;
  int                       capCount;
  int                       totalValid;
  int                       doneCount;
  int                       modelCount;
  bit                       modelActive;
  int                       dueQ[$];
  htPreamblePkg::iqSample_t capture [burstLen];

  tbClockGen uClk (.rstReq(rstReq), .clk(clk), .arstN(arstN));

  htPreambleTop #(.numLtf(2)) dut (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .sampleEn    (sampleEn),
    .gainShift   (gainShift),
    .sample      (sample),
    .sampleValid (sampleValid),
    .burstDone   (burstDone)
  );

  function automatic logic signed [15:0] gainClamp(input logic signed [15:0] x, input int shift);
    int v;
    v = int'(x) * (1 << shift);
    if (v > 32767) begin
      v = 32767;
    end else if (v < -32768) begin
      v = -32768;
    end
    return 16'(v);
  endfunction

  // expected output for burst position pos at the given gain shift.
  function automatic htPreamblePkg::iqSample_t refSample(input int pos, input int shift);
    logic [31:0]              word;
    logic signed [15:0]       i0;
    logic signed [15:0]       q0;
    int                       k;
    int                       sym;
    htPreamblePkg::iqSample_t r;
    sym = -1;
    if (pos < 80) begin
      word = stfRef[pos % 16];
    end else begin
      sym  = (pos - 80) / 80;
      k    = (pos - 80) % 80;
      word = ltfRef[(k < 64) ? k : k - 64];
    end
    i0 = word[31:16];
    q0 = word[15:0];
    if (sym >= 0 && pRowMinus[sym]) begin
      i0 = -i0;
      q0 = -q0;
    end
    r.i = gainClamp(i0, shift);
    r.q = gainClamp(q0, shift);
    return r;
  endfunction

  task automatic reportMismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("[FAIL] t=%0t %s got=0x%0h expected=0x%0h", $time, sig, got, exp);
  endtask

  task automatic reportProblem(input string what);
    errors++;
    $display("[ERROR] t=%0t %s", $time, what);
  endtask

  // ********************************************************************
  // stimulus driver and output monitor
  // ********************************************************************

  always @(posedge clk) begin
    #1;
    if (holdLow || !enRun) begin
      sampleEn = 1'b0;
    end else begin
      sampleEn = ($random(seed) & 3) != 0;
    end
  end

  // inputs seen here are sampled by the DUT at the next rising edge.
  always @(negedge clk) begin : monitor
    int due;
    cyc++;
    if (arstN !== 1'b1) begin
      modelActive = 1'b0;
      modelCount  = 0;
      dueQ.delete();
    end else begin
      if (sampleValid) begin
        totalValid++;
        checks++;
        assert (dueQ.size() != 0)
          else reportProblem("sampleValid without an accepted sampleEn");
        if (dueQ.size() != 0) begin
          due = dueQ.pop_front();
          checks++;
          assert (due == cyc) else reportMismatch("sampleValid cycle", cyc, due);
        end
        checks++;
        assert (burstDone == (capCount == burstLen - 1))
          else reportMismatch("burstDone", burstDone, capCount == burstLen - 1);
        if (capCount < burstLen) begin
          capture[capCount] = sample;
        end
        capCount++;
      end else begin
        checks++;
        assert (!burstDone) else reportProblem("burstDone high without sampleValid");
      end
      if (burstDone) begin
        doneCount++;
      end
      if (modelActive) begin
        if (sampleEn) begin
          dueQ.push_back(cyc + 2);
          modelCount++;
          modelActive = modelCount < burstLen;
        end
      end else if (start) begin
        modelActive = 1'b1;
        modelCount  = 0;
        capCount    = 0;
      end
    end
  end

  // ********************************************************************
  // test sequence
  // ********************************************************************

  task automatic pulseStart();
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic runBurst(input string name);
    int n;
    int doneBefore;
    doneBefore = doneCount;
    pulseStart();
    n = 0;
    while (doneCount == doneBefore && n < doneTimeout) begin
      @(negedge clk);
      n++;
    end
    if (doneCount == doneBefore) begin
      reportProblem($sformatf("no burstDone within %0d cycles in %s", doneTimeout, name));
    end
    repeat (4) @(posedge clk);
    checks++;
    assert (capCount == burstLen) else reportMismatch("sampleValid count", capCount, burstLen);
  endtask

  task automatic checkBurst(input int shift);
    htPreamblePkg::iqSample_t exp;
    for (int p = 0; p < burstLen; p++) begin
      exp = refSample(p, shift);
      checks++;
      assert (capture[p] == exp)
        else reportMismatch($sformatf("sample[%0d]", p), capture[p], exp);
    end
  endtask

  task automatic waitSamples(input int count);
    int n;
    n = 0;
    while ((capCount < count || !sampleValid) && n < doneTimeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (capCount < count || !sampleValid) begin
      reportProblem($sformatf("burst never reached %0d samples", count));
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    $display("[DONE] %s errors=%0d", name, errors - errBefore);
  endtask

  initial begin
    htPreamblePkg::iqSample_t neg;
    int                       errBefore;
    int                       validBefore;
    int                       n;
    rstReq    = 1'b0;
    start     = 1'b0;
    sampleEn  = 1'b0;
    gainShift = 2'd0;
    enRun     = 1'b0;
    holdLow   = 1'b0;
    n = 0;
    while (!arstN && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (!arstN) begin
      reportProblem("reset never released");
    end
    enRun = 1'b1;

    errBefore   = errors;
    validBefore = totalValid;
    repeat (30) @(posedge clk);
    checks++;
    assert (totalValid == validBefore) else reportProblem("sampleValid before any start");
    runBurst("burst length");
    finishTest("burst length and done", errBefore);

    errBefore = errors;
    checkBurst(0);
    for (int p = 0; p < 64; p++) begin
      checks++;
      assert (capture[p] == capture[p + 16])
        else reportMismatch($sformatf("stf period at %0d", p), capture[p + 16], capture[p]);
    end
    finishTest("stf content", errBefore);

    errBefore = errors;
    for (int p = 160; p < burstLen; p++) begin
      neg.i = -capture[p - 80].i;
      neg.q = -capture[p - 80].q;
      checks++;
      assert (capture[p] == neg)
        else reportMismatch($sformatf("sample[%0d]", p), capture[p], neg);
    end
    checks++;
    assert (capture[96] == 32'h14000000)
      else reportMismatch("sample[96]", capture[96], 32'h14000000);
    checks++;
    assert (capture[176] == 32'hEC000000)
      else reportMismatch("sample[176]", capture[176], 32'hEC000000);
    finishTest("ltf sign", errBefore);

    errBefore = errors;
    @(posedge clk);
    #1;
    gainShift = 2'd3;
    runBurst("gain");
    checkBurst(3);
    checks++;
    assert (capture[96].i == 16'h7FFF)
      else reportMismatch("sample[96].i", capture[96].i, 16'h7FFF);
    checks++;
    assert (capture[128].i == 16'h8000)
      else reportMismatch("sample[128].i", capture[128].i, 16'h8000);
    finishTest("gain and saturation", errBefore);

    // stall mid-burst and try a second start while it runs.
    errBefore = errors;
    @(posedge clk);
    #1;
    gainShift = 2'd0;
    fork
      runBurst("stall");
      begin
        waitSamples(60);
        holdLow = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        holdLow = 1'b0;
        pulseStart();
      end
    join
    checkBurst(0);
    finishTest("stall and ignored start", errBefore);

    errBefore = errors;
    pulseStart();
    waitSamples(100);
    rstReq = 1'b1;
    #1;
    checks++;
    assert (!sampleValid && !burstDone && sample == '0)
      else reportProblem("outputs not cleared at once by reset");
    repeat (3) @(posedge clk);
    #1;
    rstReq      = 1'b0;
    validBefore = totalValid;
    repeat (20) @(posedge clk);
    checks++;
    assert (totalValid == validBefore) else reportProblem("sampleValid after reset without start");
    runBurst("reset");
    checkBurst(0);
    finishTest("reset mid-burst", errBefore);

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
htPreamblePkg.sv
htStfRom.sv
htLtfRom.sv
preambleSequencer.sv
sampleGain.sv
htPreambleTop.sv
tbClockGen.sv
htPreambleTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module htPreambleTb -o simTb \
  && ./obj_dir/simTb > sim.log 2>&1 \
  || { echo "build or run error" >> sim.log; cat sim.log; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
